//--- core_perf.f
+incdir+.
drac_perf_pkg.sv
pmu_event_collector.sv
hpm_counters.sv
csr_perf_unit.sv
core_perf_top.sv
tb_core_perf_top.sv

//--- core_perf_golden.txt
# name op addr(hex) data(hex) count expected(hex), count is pulses on event lines, else idle cycles
all          event   000 0                3 0
minstret     read    b02 0                2 3
hpm3         read    b03 0                0 3
hpm4         read    b04 0                0 3
hpm5         read    b05 0                0 3
hpm6         read    b06 0                0 3
hpm7         read    b07 0                0 3
hpm8         read    b08 0                0 3
hpm9         read    b09 0                0 3
hpm10        read    b0a 0                0 3
wr_hpm5      write   b05 123456789abcdef0 0 3
rd_hpm5      read    b05 0                0 123456789abcdef0
inh_set      set     320 28               0 0
inh_clear    clear   320 8                0 28
inh_read     read    320 0                0 20
branch_taken event   000 0                4 0
is_branch    event   000 0                4 0
inh_hpm5     read    b05 0                2 123456789abcdef0
live_hpm4    read    b04 0                0 7
bad_addr     illegal 7c0 0                0 0
keep_hpm4    read    b04 0                0 7
mcyc_a       sample  b00 0                0 0
mcyc_b       grow    b00 0                5 0

//--- core_perf_top.sv
// core performance monitor top
`timescale 1ns/1ns
`include "drac_perf_defines.svh"

module core_perf_top (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  drac_perf_pkg::pmu_flags_t     pmu_flags_i,     // from the datapath
    input  drac_perf_pkg::pmu_interface_t pmu_interface_i, // from the memory side
    input  drac_perf_pkg::req_cpu_csr_t   req_cpu_csr_i,
    output drac_perf_pkg::resp_csr_cpu_t  resp_csr_cpu_o
);

    drac_perf_pkg::pmu_events_t    events;      // registered event vector
    drac_perf_pkg::cnt_idx_t       cnt_idx;
    logic                          cnt_we;
    logic [`HPM_COUNTER_WIDTH-1:0] cnt_wdata;
    logic                          inhibit_we;
    logic [`HPM_COUNTER_WIDTH-1:0] cnt_rdata;
    logic [31:0]                   inhibit_q;

    // --------------------------------------------------
    // event path
    // --------------------------------------------------
    pmu_event_collector i_pmu_event_collector (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .pmu_flags_i     (pmu_flags_i),
        .pmu_interface_i (pmu_interface_i),
        .events_o        (events)
    );

    hpm_counters i_hpm_counters (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .events_i     (events),
        .cnt_idx_i    (cnt_idx),
        .cnt_we_i     (cnt_we),
        .cnt_wdata_i  (cnt_wdata),
        .inhibit_we_i (inhibit_we),
        .cnt_rdata_o  (cnt_rdata),
        .inhibit_o    (inhibit_q)
    );

    // --------------------------------------------------
    // csr access path
    // --------------------------------------------------
    csr_perf_unit i_csr_perf_unit (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .req_cpu_csr_i  (req_cpu_csr_i),
        .cnt_rdata_i    (cnt_rdata),
        .inhibit_i      (inhibit_q),
        .cnt_idx_o      (cnt_idx),
        .cnt_we_o       (cnt_we),
        .cnt_wdata_o    (cnt_wdata),
        .inhibit_we_o   (inhibit_we),
        .resp_csr_cpu_o (resp_csr_cpu_o)
    );

endmodule

//--- csr_perf_unit.sv
// performance csr access unit
`timescale 1ns/1ns
`include "drac_perf_defines.svh"

module csr_perf_unit (
    input  logic                            clk_i,
    input  logic                            rstn_i,
    input  drac_perf_pkg::req_cpu_csr_t     req_cpu_csr_i,
    input  logic [`HPM_COUNTER_WIDTH-1:0]   cnt_rdata_i,    // selected counter, combinational
    input  logic [31:0]                     inhibit_i,
    output drac_perf_pkg::cnt_idx_t         cnt_idx_o,
    output logic                            cnt_we_o,
    output logic [`HPM_COUNTER_WIDTH-1:0]   cnt_wdata_o,
    output logic                            inhibit_we_o,
    output drac_perf_pkg::resp_csr_cpu_t    resp_csr_cpu_o
);

    logic [`CSR_ADDR_SIZE-1:0]     addr_off;    // offset from mcycle
    logic                          is_cnt;      // address hits a counter
    logic                          is_inh;      // address hits mcountinhibit
    logic                          illegal;
    logic                          modify;      // command changes the register
    logic [`HPM_COUNTER_WIDTH-1:0] old_val;
    logic [`HPM_COUNTER_WIDTH-1:0] new_val;

    logic                          rvalid_q;
    logic                          xcpt_q;
    logic [`HPM_COUNTER_WIDTH-1:0] rdata_q;

    // --------------------------------------------------
    // address decode
    // --------------------------------------------------
    always_comb begin
        addr_off = req_cpu_csr_i.addr - `CSR_MCYCLE;
        is_cnt   = (req_cpu_csr_i.addr == `CSR_MCYCLE)
                || (req_cpu_csr_i.addr == `CSR_MINSTRET)
                || ((req_cpu_csr_i.addr >= `CSR_MHPMCOUNTER3)
                    && (req_cpu_csr_i.addr <
                        `CSR_MHPMCOUNTER3 + `CSR_ADDR_SIZE'(`HPM_NUM_COUNTERS)));
        is_inh   = (req_cpu_csr_i.addr == `CSR_MCOUNTINHIBIT);
        illegal  = !(is_cnt || is_inh);  // 0xb01 (time) lands here too
    end

    assign cnt_idx_o = addr_off[$bits(drac_perf_pkg::cnt_idx_t)-1:0];

    // inhibit is 32 bit wide, zero extend to the data width
    assign old_val = is_inh ? `HPM_COUNTER_WIDTH'(inhibit_i) : cnt_rdata_i;

    // --------------------------------------------------
    // read-modify-write
    // --------------------------------------------------
    always_comb begin
        new_val = old_val;
        modify  = 1'b0;
        case (req_cpu_csr_i.cmd)
            drac_perf_pkg::CSR_WRITE: begin
                new_val = req_cpu_csr_i.wdata;
                modify  = 1'b1;
            end
            drac_perf_pkg::CSR_SET: begin
                new_val = old_val | req_cpu_csr_i.wdata;
                modify  = 1'b1;
            end
            drac_perf_pkg::CSR_CLEAR: begin
                new_val = old_val & ~req_cpu_csr_i.wdata;
                modify  = 1'b1;
            end
            default: begin          // read and none leave the register alone
                new_val = old_val;
                modify  = 1'b0;
            end
        endcase
    end

    assign cnt_wdata_o  = new_val;
    assign cnt_we_o     = req_cpu_csr_i.valid && modify && is_cnt;  // lands at this edge
    assign inhibit_we_o = req_cpu_csr_i.valid && modify && is_inh;

    // --------------------------------------------------
    // response, one cycle after the request
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rvalid_q <= 1'b0;
            xcpt_q   <= 1'b0;
        end else begin
            rvalid_q <= req_cpu_csr_i.valid && (req_cpu_csr_i.cmd != drac_perf_pkg::CSR_NONE);
            xcpt_q   <= req_cpu_csr_i.valid && (req_cpu_csr_i.cmd != drac_perf_pkg::CSR_NONE)
                        && illegal;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_cpu_csr_i.valid) begin
            rdata_q <= illegal ? '0 : old_val;  // old value, even for set and clear
        end
    end

    assign resp_csr_cpu_o.rvalid = rvalid_q;
    assign resp_csr_cpu_o.rdata  = rdata_q;
    assign resp_csr_cpu_o.xcpt   = xcpt_q;

endmodule

//--- drac_perf_defines.svh
// performance monitor defines
`ifndef DRAC_PERF_DEFINES_SVH
`define DRAC_PERF_DEFINES_SVH

// --------------------------------------------------
// counter bank sizing
// --------------------------------------------------
`define HPM_NUM_COUNTERS  8   // programmable event counters, also the event vector width
`define HPM_COUNTER_WIDTH 64  // counter and csr data width

// --------------------------------------------------
// csr address map
// --------------------------------------------------
`define CSR_ADDR_SIZE     12

`define CSR_MCYCLE        12'hB00
`define CSR_MINSTRET      12'hB02
`define CSR_MHPMCOUNTER3  12'hB03  // first of the event counters, mhpmcounter3+i counts event i
`define CSR_MCOUNTINHIBIT 12'h320

`endif

//--- drac_perf_pkg.sv
// performance monitor types
`include "drac_perf_defines.svh"

package drac_perf_pkg;

    // --------------------------------------------------
    // raw flags from the core
    // --------------------------------------------------
    typedef struct packed {
        logic retire;        // instruction retired this cycle
        logic is_branch;
        logic branch_taken;
        logic branch_miss;   // mispredicted branch
        logic stall_if;
        logic stall_exe;
    } pmu_flags_t;

    typedef struct packed {
        logic exe_load;      // load issued to the dcache
        logic exe_store;
        logic icache_miss;
    } pmu_interface_t;

    // merged vector, events[i] feeds mhpmcounter3+i
    typedef struct packed {
        logic                          retire;
        logic [`HPM_NUM_COUNTERS-1:0]  events;
    } pmu_events_t;

    // index into the counter bank, offset from mcycle (0 .. N+2)
    typedef logic [$clog2(`HPM_NUM_COUNTERS+3)-1:0] cnt_idx_t;

    // --------------------------------------------------
    // csr access from the core
    // --------------------------------------------------
    typedef enum logic [2:0] {
        CSR_NONE  = 3'd0,
        CSR_READ  = 3'd1,
        CSR_WRITE = 3'd2,
        CSR_SET   = 3'd3,   // or the data into the register
        CSR_CLEAR = 3'd4    // and-not the data out of the register
    } csr_cmd_t;

    typedef struct packed {
        logic                          valid;
        csr_cmd_t                      cmd;
        logic [`CSR_ADDR_SIZE-1:0]     addr;
        logic [`HPM_COUNTER_WIDTH-1:0] wdata;
    } req_cpu_csr_t;

    typedef struct packed {
        logic                          rvalid;  // one cycle pulse
        logic [`HPM_COUNTER_WIDTH-1:0] rdata;   // value before the access
        logic                          xcpt;    // illegal address
    } resp_csr_cpu_t;

endpackage

//--- hpm_counters.sv
// hardware performance counter bank
`timescale 1ns/1ns
`include "drac_perf_defines.svh"

module hpm_counters (
    input  logic                            clk_i,
    input  logic                            rstn_i,
    input  drac_perf_pkg::pmu_events_t      events_i,     // registered events
    input  drac_perf_pkg::cnt_idx_t         cnt_idx_i,    // counter select, offset from mcycle
    input  logic                            cnt_we_i,     // counter write strobe
    input  logic [`HPM_COUNTER_WIDTH-1:0]   cnt_wdata_i,
    input  logic                            inhibit_we_i, // mcountinhibit write strobe
    output logic [`HPM_COUNTER_WIDTH-1:0]   cnt_rdata_o,
    output logic [31:0]                     inhibit_o
);

    localparam drac_perf_pkg::cnt_idx_t IDX_MCYCLE   = drac_perf_pkg::cnt_idx_t'(0);
    localparam drac_perf_pkg::cnt_idx_t IDX_MINSTRET = drac_perf_pkg::cnt_idx_t'(2);
    localparam int                      IDX_HPM_BASE = 3;

    // implemented inhibit bits: cy, ir and one per event counter, tm stays zero
    localparam logic [31:0] INHIBIT_MASK = 32'({{`HPM_NUM_COUNTERS{1'b1}}, 3'b101});

    logic [`HPM_COUNTER_WIDTH-1:0] mcycle_q;
    logic [`HPM_COUNTER_WIDTH-1:0] minstret_q;
    logic [`HPM_COUNTER_WIDTH-1:0] hpm_q [`HPM_NUM_COUNTERS];
    logic [31:0]                   inhibit_q;

    // --------------------------------------------------
    // fixed counters
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            mcycle_q <= '0;
        end else if (cnt_we_i && (cnt_idx_i == IDX_MCYCLE)) begin
            mcycle_q <= cnt_wdata_i;          // csr write beats the increment
        end else if (!inhibit_q[0]) begin
            mcycle_q <= mcycle_q + 1'b1;      // free running
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            minstret_q <= '0;
        end else if (cnt_we_i && (cnt_idx_i == IDX_MINSTRET)) begin
            minstret_q <= cnt_wdata_i;
        end else if (events_i.retire && !inhibit_q[2]) begin
            minstret_q <= minstret_q + 1'b1;
        end
    end

    // --------------------------------------------------
    // event counters, hardwired event i -> counter 3+i
    // --------------------------------------------------
    for (genvar i = 0; i < `HPM_NUM_COUNTERS; i++) begin : g_hpm
        logic hit;  // this counter addressed by the write port
        logic inc;

        assign hit = cnt_we_i && (cnt_idx_i == drac_perf_pkg::cnt_idx_t'(IDX_HPM_BASE + i));
        assign inc = events_i.events[i] && !inhibit_q[IDX_HPM_BASE + i];

        always_ff @(posedge clk_i or negedge rstn_i) begin
            if (!rstn_i) begin
                hpm_q[i] <= '0;
            end else if (hit) begin
                hpm_q[i] <= cnt_wdata_i;
            end else if (inc) begin
                hpm_q[i] <= hpm_q[i] + 1'b1;
            end
        end
    end

    // mcountinhibit, unimplemented bits read as zero
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            inhibit_q <= '0;
        end else if (inhibit_we_i) begin
            inhibit_q <= cnt_wdata_i[31:0] & INHIBIT_MASK;
        end
    end

    // --------------------------------------------------
    // read port
    // --------------------------------------------------
    always_comb begin
        cnt_rdata_o = '0;                     // holes in the map read zero
        if (cnt_idx_i == IDX_MCYCLE) begin
            cnt_rdata_o = mcycle_q;
        end
        if (cnt_idx_i == IDX_MINSTRET) begin
            cnt_rdata_o = minstret_q;
        end
        for (int i = 0; i < `HPM_NUM_COUNTERS; i++) begin
            if (cnt_idx_i == drac_perf_pkg::cnt_idx_t'(IDX_HPM_BASE + i)) begin
                cnt_rdata_o = hpm_q[i];
            end
        end
    end

    assign inhibit_o = inhibit_q;

endmodule

//--- pmu_event_collector.sv
// pmu event collector
`timescale 1ns/1ns

module pmu_event_collector (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  drac_perf_pkg::pmu_flags_t     pmu_flags_i,      // datapath flags
    input  drac_perf_pkg::pmu_interface_t pmu_interface_i,  // memory side flags
    output drac_perf_pkg::pmu_events_t    events_o
);

    drac_perf_pkg::pmu_events_t events_d;  // merged, not yet registered
    drac_perf_pkg::pmu_events_t events_q;

    // --------------------------------------------------
    // merge into the fixed event order
    // --------------------------------------------------
    // bit 0 is branch_miss and feeds mhpmcounter3, bit 7 feeds mhpmcounter10
    always_comb begin
        events_d.retire = pmu_flags_i.retire;
        events_d.events = {
            pmu_interface_i.icache_miss,  // event 7
            pmu_interface_i.exe_store,    // event 6
            pmu_interface_i.exe_load,     // event 5
            pmu_flags_i.stall_exe,        // event 4
            pmu_flags_i.stall_if,         // event 3
            pmu_flags_i.branch_taken,     // event 2
            pmu_flags_i.is_branch,        // event 1
            pmu_flags_i.branch_miss       // event 0
        };
    end

    // --------------------------------------------------
    // pipeline register
    // --------------------------------------------------
    // flags come from far corners of the core and arrive late in the cycle,
    // one flop stage keeps that path away from the 64 bit adders
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            events_q <= '0;
        end else begin
            events_q <= events_d;  // new sample every cycle
        end
    end

    assign events_o = events_q;

endmodule

//--- run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f core_perf.f \
    --top-module tb_core_perf_top -o sim_core_perf &&
./obj_dir/sim_core_perf | tee /dev/stderr | grep -qF "** PASS **" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- tb_core_perf_top.sv
// core performance monitor testbench
`timescale 1ns/1ns
`include "drac_perf_defines.svh"

module tb_core_perf_top;

    localparam int NAMEW = 8*24;                     // golden tokens up to 24 characters

    logic                          clk_i = 1'b0;
    logic                          rstn_i;
    drac_perf_pkg::pmu_flags_t     pmu_flags;        // datapath flags
    drac_perf_pkg::pmu_interface_t pmu_interface;    // memory side flags
    drac_perf_pkg::req_cpu_csr_t   req;
    drac_perf_pkg::resp_csr_cpu_t  resp;
    integer                        seed = 32'hd5989524;
    logic [`HPM_COUNTER_WIDTH-1:0] shadow_inh;       // mcountinhibit as the csr rules give it

    core_perf_top i_core_perf_top (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .pmu_flags_i     (pmu_flags),
        .pmu_interface_i (pmu_interface),
        .req_cpu_csr_i   (req),
        .resp_csr_cpu_o  (resp)
    );

    always #2 clk_i = ~clk_i;                        // 4 ns period

    // --------------------------------------------------
    // checks and flag drive
    // --------------------------------------------------
    task automatic fail_now;
        $display("** FAIL **");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input logic [NAMEW-1:0] test,
                               input logic [`HPM_COUNTER_WIDTH-1:0] exp,
                               input logic [`HPM_COUNTER_WIDTH-1:0] act);
        assert (act === exp) else begin
            $display("mismatch %0s expected %h actual %h", test, exp, act);
            fail_now();
        end
    endtask

    // golden event lines name the flag, all hits every flag at once
    task automatic drive_flag(input logic [NAMEW-1:0] name, input logic val);
        case (name)
            "all":          {pmu_flags, pmu_interface} <= {9{val}};
            "retire":       pmu_flags.retire <= val;
            "is_branch":    pmu_flags.is_branch <= val;
            "branch_taken": pmu_flags.branch_taken <= val;
            "branch_miss":  pmu_flags.branch_miss <= val;
            "stall_if":     pmu_flags.stall_if <= val;
            "stall_exe":    pmu_flags.stall_exe <= val;
            "exe_load":     pmu_interface.exe_load <= val;
            "exe_store":    pmu_interface.exe_store <= val;
            "icache_miss":  pmu_interface.icache_miss <= val;
            default: begin
                $display("unknown event flag %0s in the golden file", name);
                fail_now();
            end
        endcase
    endtask

    // --------------------------------------------------
    // golden file walk
    // --------------------------------------------------
    initial begin
        integer                        fd;
        integer                        code;
        integer                        cnt;              // pulses, or idle cycles before a csr op
        integer                        tries;
        logic [NAMEW-1:0]              name;
        logic [NAMEW-1:0]              op;
        logic [8*128-1:0]              skip;             // rest of a header line
        logic [`CSR_ADDR_SIZE-1:0]     addr;
        logic [`HPM_COUNTER_WIDTH-1:0] data;
        logic [`HPM_COUNTER_WIDTH-1:0] exp;
        logic [`HPM_COUNTER_WIDTH-1:0] first_cyc;        // mcycle sample for the grow check
        drac_perf_pkg::csr_cmd_t       cmd;

        rstn_i        = 1'b0;
        pmu_flags     = '0;
        pmu_interface = '0;
        req           = '0;
        shadow_inh    = '0;
        first_cyc     = '0;
        cmd           = drac_perf_pkg::CSR_NONE;
        repeat (4) @(posedge clk_i);
        rstn_i <= 1'b1;
        fd = $fopen("core_perf_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open core_perf_golden.txt");
            fail_now();
        end
        while ($fscanf(fd, "%s", name) == 1) begin
            if (name == "#") begin
                code = $fgets(skip, fd);
            end else begin
                code = $fscanf(fd, "%s %h %h %d %h", op, addr, data, cnt, exp);
                if (code != 5) begin
                    $display("golden line %0s has missing fields", name);
                    fail_now();
                end
                if (op == "event") begin
                    for (int p = 0; p < cnt; p++) begin
                        @(posedge clk_i);
                        drive_flag(name, 1'b1);          // one cycle pulse
                        @(posedge clk_i);
                        drive_flag(name, 1'b0);
                        repeat ($unsigned($random(seed)) % 3) @(posedge clk_i);
                    end
                end else begin
                    case (op)
                        "write":   cmd = drac_perf_pkg::CSR_WRITE;
                        "set":     cmd = drac_perf_pkg::CSR_SET;
                        "clear":   cmd = drac_perf_pkg::CSR_CLEAR;
                        "read", "illegal", "sample", "grow": cmd = drac_perf_pkg::CSR_READ;
                        default: begin
                            $display("unknown operation %0s on golden line %0s", op, name);
                            fail_now();
                        end
                    endcase
                    repeat (cnt) @(posedge clk_i);
                    @(posedge clk_i);
                    req.valid <= 1'b1;
                    req.cmd   <= cmd;
                    req.addr  <= addr;
                    req.wdata <= data;
                    @(posedge clk_i);
                    req.valid <= 1'b0;                   // dut takes the request at this edge
                    tries = 0;
                    do begin
                        @(posedge clk_i);
                        tries++;
                    end while (!resp.rvalid && tries < 20);
                    if (!resp.rvalid) begin
                        $display("no csr response for %0s within 20 cycles", name);
                        fail_now();
                    end
                    assert (resp.xcpt == (op == "illegal")) else begin
                        $display("mismatch %0s expected xcpt %b actual %b",
                                 name, op == "illegal", resp.xcpt);
                        fail_now();
                    end
                    if (op == "sample") begin
                        first_cyc = resp.rdata;
                    end else if (op == "grow") begin
                        assert (resp.rdata > first_cyc) else begin
                            $display("mismatch %0s expected above %h actual %h",
                                     name, first_cyc, resp.rdata);
                            fail_now();
                        end
                    end else begin
                        check_value(name, exp, resp.rdata);   // old value of the register
                    end
                    // mcountinhibit model, old value first then the update
                    if (addr == `CSR_MCOUNTINHIBIT) begin
                        check_value(name, shadow_inh, resp.rdata);
                        case (cmd)
                            drac_perf_pkg::CSR_WRITE: shadow_inh = data;
                            drac_perf_pkg::CSR_SET:   shadow_inh = shadow_inh | data;
                            drac_perf_pkg::CSR_CLEAR: shadow_inh = shadow_inh & ~data;
                            default: ;
                        endcase
                    end
                end
            end
        end
        $fclose(fd);
        $display("** PASS **");
        $finish;
    end

endmodule
